//--- files.f
logic/pipe_pkg.sv
logic/stage_if.sv
logic/stage_reg.sv
logic/execute_stage.sv
logic/commit_ctrl.sv
logic/pipe_core.sv
verif/pipe_core_checker.sv
verif/pipe_core_tb.sv

//--- logic/commit_ctrl.sv
`timescale 1ns/100ps

module commit_ctrl import pipe_pkg::*; #(
    parameter logic [XLEN-1:0] EX_ENTRY = 32'h1c008000
) (
    input  logic            aclk,
    input  logic            reset,
    stage_if.consumer       head,
    input  logic            retire_ready,
    output logic            retire_valid,
    output logic [XLEN-1:0] retire_pc,
    output logic [XLEN-1:0] retire_result,
    output logic            flush,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc,
    output logic            in_ready_block
);

    typedef enum logic {
        ST_RUN,
        ST_HANDLER
    } state_e;

    state_e          state_q;
    logic [XLEN-1:0] era_q;
    logic            head_live;
    logic            is_syscall;
    logic            is_ertn;
    logic            take_syscall;
    logic            take_ertn;
    logic            take_ex;

    assign head_live  = head.valid && head.ready_go;
    assign is_syscall = head.item.op == OP_SYSCALL;
    assign is_ertn    = head.item.op == OP_ERTN;

    assign take_syscall = head_live && is_syscall;
    // ertn outside the handler is dropped without effect
    assign take_ertn    = head_live && is_ertn && (state_q == ST_HANDLER);
    assign take_ex      = take_syscall || take_ertn;

    // Control ops never wait on the retire port
    assign head.allow_in = retire_ready || is_syscall || is_ertn;

    assign retire_valid  = head_live && !is_syscall && !is_ertn;
    assign retire_pc     = head.item.pc;
    assign retire_result = head.item.result;

    // Flush, redirect and input block are one event
    assign flush          = take_ex;
    assign redirect_valid = take_ex;
    assign in_ready_block = take_ex;
    assign redirect_pc    = take_syscall ? EX_ENTRY : era_q;

    always_ff @(posedge aclk)
    begin
        if (reset)
            state_q <= ST_RUN;
        else if (take_syscall)
            state_q <= ST_HANDLER;
        else if (take_ertn)
            state_q <= ST_RUN;
    end

    // Return address, re-saved by a nested syscall
    always_ff @(posedge aclk)
    begin
        if (take_syscall)
            era_q <= head.item.pc;
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import pipe_pkg::*; (
    input  logic        aclk,
    input  logic        reset,
    input  logic        flush,
    stage_if.consumer   up,
    stage_if.producer   down
);

    logic [TIMER_W-1:0] timer_q;
    logic               mul_busy;
    logic               is_mul;
    logic               ex_done;
    logic [XLEN-1:0]    mul_prod;
    exe_item_t          ex_item;

    // Free-running stable timer
    always_ff @(posedge aclk)
    begin
        if (reset)
            timer_q <= '0;
        else
            timer_q <= timer_q + 1'b1;
    end

    assign is_mul = up.valid && (up.item.op == OP_MUL);

    // Multiply holds the stage for its first cycle
    assign ex_done = !is_mul || mul_busy;

    always_ff @(posedge aclk)
    begin
        if (reset || flush)
        begin
            mul_busy <= 1'b0;
        end
        else if (is_mul && !mul_busy)
        begin
            mul_busy <= 1'b1;
        end
        else if (mul_busy && down.allow_in)
        begin
            // Second cycle done and the product has moved on
            mul_busy <= 1'b0;
        end
    end

    // Low half times high half, both unsigned
    assign mul_prod = up.item.operand[XLEN/2-1:0] * up.item.operand[XLEN-1:XLEN/2];

    always_comb
    begin
        ex_item.pc = up.item.pc;
        ex_item.op = up.item.op;
        case (up.item.op)
            OP_MUL:      ex_item.result = mul_prod;
            OP_RDCNT_LO: ex_item.result = timer_q[XLEN-1:0];
            OP_RDCNT_HI: ex_item.result = timer_q[TIMER_W-1:XLEN];
            // Pass and control ops carry the operand
            default:     ex_item.result = up.item.operand;
        endcase
    end

    assign down.valid    = up.valid;
    assign down.item     = ex_item;
    assign down.ready_go = up.ready_go && ex_done;

    // The id item leaves only once complete and accepted by wb
    assign up.allow_in = down.allow_in && ex_done;

endmodule

//--- logic/pipe_core.sv
`timescale 1ns/100ps

module pipe_core import pipe_pkg::*; #(
    parameter logic [XLEN-1:0] EX_ENTRY = 32'h1c008000
) (
    input  logic            aclk,
    input  logic            reset,

    // Issue side
    input  logic            in_valid,
    input  logic [XLEN-1:0] in_pc,
    input  op_e             in_op,
    input  logic [XLEN-1:0] in_operand,
    output logic            in_ready,

    // Retire side
    output logic            retire_valid,
    output logic [XLEN-1:0] retire_pc,
    output logic [XLEN-1:0] retire_result,
    input  logic            retire_ready,

    // Fetch redirect
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc
);

    logic flush;
    logic in_ready_block;

    stage_if #(.T(issue_item_t)) in_link ();
    stage_if #(.T(issue_item_t)) id_link ();
    stage_if #(.T(exe_item_t))   ex_link ();
    stage_if #(.T(exe_item_t))   wb_link ();

    // Front producer built from the issue ports
    assign in_link.valid         = in_valid;
    assign in_link.item.pc       = in_pc;
    assign in_link.item.op       = in_op;
    assign in_link.item.operand  = in_operand;
    assign in_link.ready_go      = 1'b1;

    // Closed during reset and in the flush cycle
    assign in_ready = in_link.allow_in && !in_ready_block && !reset;

    stage_reg #(
        .T (issue_item_t)
    ) id_reg (
        .aclk  (aclk),
        .reset (reset),
        .flush (flush),
        .up    (in_link),
        .down  (id_link)
    );

    execute_stage u_execute (
        .aclk  (aclk),
        .reset (reset),
        .flush (flush),
        .up    (id_link),
        .down  (ex_link)
    );

    stage_reg #(
        .T (exe_item_t)
    ) wb_reg (
        .aclk  (aclk),
        .reset (reset),
        .flush (flush),
        .up    (ex_link),
        .down  (wb_link)
    );

    // Commit drives the global flush back into every stage
    commit_ctrl #(
        .EX_ENTRY (EX_ENTRY)
    ) u_commit (
        .aclk           (aclk),
        .reset          (reset),
        .head           (wb_link),
        .retire_ready   (retire_ready),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_result  (retire_result),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .in_ready_block (in_ready_block)
    );

endmodule

//--- logic/pipe_pkg.sv
package pipe_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Stable timer spans two words
    localparam int TIMER_W = 2 * XLEN;

    // Pre-decoded operation carried with each item
    typedef enum logic [2:0] {
        OP_PASS     = 3'd0,
        OP_MUL      = 3'd1,
        OP_RDCNT_LO = 3'd2,
        OP_RDCNT_HI = 3'd3,
        OP_SYSCALL  = 3'd4,
        OP_ERTN     = 3'd5
    } op_e;

    // Item held in the id register, as supplied by the issue source
    typedef struct packed {
        logic [XLEN-1:0] pc;
        op_e             op;
        logic [XLEN-1:0] operand;
    } issue_item_t;

    // Item leaving execute, result replaces the operand
    typedef struct packed {
        logic [XLEN-1:0] pc;
        op_e             op;
        logic [XLEN-1:0] result;
    } exe_item_t;

endpackage

//--- logic/stage_if.sv
`timescale 1ns/100ps

// One stage-to-stage link, transfer when valid, ready_go and allow_in are high
interface stage_if #(
    parameter type T = logic
);
    logic valid;
    T     item;
    logic ready_go;
    logic allow_in;

    modport producer (
        output valid,
        output item,
        output ready_go,
        input  allow_in
    );

    modport consumer (
        input  valid,
        input  item,
        input  ready_go,
        output allow_in
    );

endinterface

//--- logic/stage_reg.sv
`timescale 1ns/100ps

module stage_reg #(
    parameter type T = logic
) (
    input  logic        aclk,
    input  logic        reset,
    input  logic        flush,
    stage_if.consumer   up,
    stage_if.producer   down
);

    logic valid_q;
    T     item_q;

    // Take a new item when empty or when the held one moves on
    assign up.allow_in = !valid_q || down.allow_in;

    // A held item is always complete
    assign down.valid    = valid_q;
    assign down.item     = item_q;
    assign down.ready_go = 1'b1;

    always_ff @(posedge aclk)
    begin
        if (reset || flush)
        begin
            valid_q <= 1'b0;
        end
        else if (up.allow_in)
        begin
            // Upstream not ready leaves a bubble in this slot
            valid_q <= up.valid && up.ready_go;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (up.allow_in && up.ready_go)
        begin
            item_q <= up.item;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the pipe_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f files.f --top-module pipe_core_tb -o sim_pipe_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_pipe_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1

//--- verif/pipe_core_checker.sv
`timescale 1ns/100ps

module pipe_core_checker import pipe_pkg::*; (
    input logic            aclk,
    input logic            reset,
    input logic            in_ready,
    input logic            retire_valid,
    input logic            retire_ready,
    input logic [XLEN-1:0] retire_pc,
    input logic [XLEN-1:0] retire_result,
    input logic            redirect_valid
);

    // Quiet outputs once reset has been seen for a full cycle
    a_reset_quiet: assert property (
        @(posedge aclk) reset && $past(reset) |-> !retire_valid && !redirect_valid
    ) else $error("retire or redirect active during reset");

    // Stalled retire holds its data
    a_stall_hold: assert property (
        @(posedge aclk) disable iff (reset)
        retire_valid && !retire_ready |=>
            retire_valid && $stable(retire_pc) && $stable(retire_result)
    ) else $error("retire outputs changed while stalled");

    a_redirect_blocks_in: assert property (
        @(posedge aclk) disable iff (reset)
        redirect_valid |-> !in_ready
    ) else $error("in_ready high during redirect");

    // Flush empties wb, so nothing retires right after
    a_redirect_clears_retire: assert property (
        @(posedge aclk) disable iff (reset)
        redirect_valid |=> !retire_valid
    ) else $error("retire_valid high right after redirect");

endmodule

//--- verif/pipe_core_tb.sv
`timescale 1ns/100ps

module pipe_core_tb import pipe_pkg::*; ();

    localparam logic [XLEN-1:0] EX_ENTRY = 32'h1c008000;
    localparam int N_RAND      = 60;
    localparam int N_FILL      = 12;
    // Rough cycle count of reset, random items, exception sequence and fill
    localparam int STIM_CYCLES = 8 + 4 * N_RAND + 40 + 2 * N_FILL;

    typedef struct {
        logic [XLEN-1:0] pc;
        op_e             op;
        logic [XLEN-1:0] exp;
    } ref_t;

    logic            aclk;
    logic            reset;
    logic            in_valid;
    logic [XLEN-1:0] in_pc;
    op_e             in_op;
    logic [XLEN-1:0] in_operand;
    logic            in_ready;
    logic            retire_valid;
    logic [XLEN-1:0] retire_pc;
    logic [XLEN-1:0] retire_result;
    logic            retire_ready;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;

    integer          seed = 32'h72f4d97f;
    int              mismatches = 0;
    int              failures = 0;
    int              redirects = 0;
    int              rr_mode = 0;
    logic [XLEN-1:0] next_pc = 32'h1c000000;
    logic [XLEN-1:0] last_lo = '0;
    logic            have_lo = 1'b0;
    logic            in_handler = 1'b0;
    logic [XLEN-1:0] era = '0;
    logic            saw_low;
    logic            acc;
    ref_t            ref_q[$];
    ref_t            head_e;
    ref_t            new_e;
    logic [XLEN-1:0] r;

    pipe_core #(
        .EX_ENTRY (EX_ENTRY)
    ) UUT (
        .aclk           (aclk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_pc          (in_pc),
        .in_op          (in_op),
        .in_operand     (in_operand),
        .in_ready       (in_ready),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_result  (retire_result),
        .retire_ready   (retire_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    bind pipe_core pipe_core_checker checker_i (
        .aclk           (aclk),
        .reset          (reset),
        .in_ready       (in_ready),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_pc      (retire_pc),
        .retire_result  (retire_result),
        .redirect_valid (redirect_valid)
    );

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // Expected result from the operation rules
    function automatic logic [XLEN-1:0] expected_result(op_e op, logic [XLEN-1:0] operand);
        if (op == OP_MUL)
            return operand[15:0] * operand[31:16];
        return operand;
    endfunction

    // ertn outside the handler is dropped by commit
    task automatic drop_silent_ertn();
        while (ref_q.size() > 0 && ref_q[0].op == OP_ERTN && !in_handler)
            void'(ref_q.pop_front());
    endtask

    task automatic send_item(input op_e op, input logic [XLEN-1:0] operand);
        in_valid   = 1'b1;
        in_pc      = next_pc;
        in_op      = op;
        in_operand = operand;
        @(posedge aclk);
        while (!in_ready)
            @(posedge aclk);
        @(negedge aclk);
        in_valid = 1'b0;
        next_pc  = next_pc + 4;
    endtask

    task automatic drain_queue();
        rr_mode = 1;
        while (ref_q.size() != 0)
            @(negedge aclk);
    endtask

    // Retire back-pressure, 0 random, 1 open, 2 closed
    always @(negedge aclk)
    begin
        if (rr_mode == 0)
            retire_ready = ($random(seed) % 4) != 0;
        else
            retire_ready = (rr_mode == 1);
    end

    // Reference model at the clock edge
    always @(posedge aclk)
    begin
        if (!reset)
        begin
            if (in_valid && in_ready)
            begin
                new_e.pc  = in_pc;
                new_e.op  = in_op;
                new_e.exp = expected_result(in_op, in_operand);
                ref_q.push_back(new_e);
            end
            if (redirect_valid)
            begin
                redirects++;
                drop_silent_ertn();
                if (ref_q.size() == 0)
                begin
                    failures++;
                    $display("Redirect at %0t with no control op pending", $time);
                end
                else
                begin
                    head_e = ref_q.pop_front();
                    if (head_e.op == OP_SYSCALL)
                    begin
                        assert (redirect_pc == EX_ENTRY) else
                        begin
                            mismatches++;
                            $display("MISMATCH t=%0t redirect_pc got %h exp %h",
                                     $time, redirect_pc, EX_ENTRY);
                        end
                        in_handler = 1'b1;
                        era = head_e.pc;
                    end
                    else if (head_e.op == OP_ERTN)
                    begin
                        assert (redirect_pc == era) else
                        begin
                            mismatches++;
                            $display("MISMATCH t=%0t redirect_pc got %h exp %h",
                                     $time, redirect_pc, era);
                        end
                        in_handler = 1'b0;
                    end
                    else
                    begin
                        failures++;
                        $display("Redirect at %0t caused by a data item", $time);
                    end
                end
                // Younger items are flushed
                ref_q.delete();
            end
            else if (retire_valid && retire_ready)
            begin
                drop_silent_ertn();
                if (ref_q.size() == 0)
                begin
                    failures++;
                    $display("Unexpected retire at %0t, pc %h", $time, retire_pc);
                end
                else
                begin
                    head_e = ref_q.pop_front();
                    assert (retire_pc == head_e.pc) else
                    begin
                        mismatches++;
                        $display("MISMATCH t=%0t retire_pc got %h exp %h",
                                 $time, retire_pc, head_e.pc);
                    end
                    case (head_e.op)
                        OP_PASS, OP_MUL:
                        begin
                            assert (retire_result == head_e.exp) else
                            begin
                                mismatches++;
                                $display("MISMATCH t=%0t retire_result got %h exp %h",
                                         $time, retire_result, head_e.exp);
                            end
                        end
                        OP_RDCNT_LO:
                        begin
                            assert (!have_lo || retire_result > last_lo) else
                            begin
                                failures++;
                                $display("Timer low read at %0t did not increase: %h after %h",
                                         $time, retire_result, last_lo);
                            end
                            last_lo = retire_result;
                            have_lo = 1'b1;
                        end
                        OP_RDCNT_HI:
                        begin
                            assert (retire_result == '0) else
                            begin
                                mismatches++;
                                $display("MISMATCH t=%0t retire_result got %h exp %h",
                                         $time, retire_result, 32'h0);
                            end
                        end
                        default:
                        begin
                            failures++;
                            $display("Control op retired at %0t, pc %h", $time, retire_pc);
                        end
                    endcase
                end
            end
        end
    end

    initial
    begin
        #(4 * STIM_CYCLES * 40);
        $display("Timeout: run did not complete in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_op        = OP_PASS;
        in_operand   = '0;
        retire_ready = 1'b0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        // Random data stream under back-pressure
        rr_mode = 0;
        for (int i = 0; i < N_RAND; i++)
        begin
            r = $random(seed);
            case (r[1:0])
                2'd0: send_item(OP_PASS, $random(seed));
                2'd1: send_item(OP_MUL, $random(seed));
                2'd2: send_item(OP_RDCNT_LO, $random(seed));
                default: send_item(OP_RDCNT_HI, $random(seed));
            endcase
        end
        drain_queue();

        // Exception entry and return
        send_item(OP_PASS, 32'h11111111);
        send_item(OP_SYSCALL, 32'h0);
        send_item(OP_PASS, 32'h22222222);
        send_item(OP_PASS, 32'h33333333);
        wait (redirects == 1);
        @(negedge aclk);
        send_item(OP_PASS, 32'h44444444);
        send_item(OP_ERTN, 32'h0);
        send_item(OP_PASS, 32'h55555555);
        wait (redirects == 2);
        @(negedge aclk);
        send_item(OP_ERTN, 32'h0);
        send_item(OP_PASS, 32'h66666666);
        send_item(OP_MUL, 32'h00030007);
        drain_queue();

        // Closed retire port fills the pipeline
        rr_mode = 2;
        saw_low = 1'b0;
        in_valid = 1'b1;
        in_op    = OP_PASS;
        for (int i = 0; i < N_FILL; i++)
        begin
            in_pc      = next_pc;
            in_operand = next_pc ^ 32'ha5a5a5a5;
            @(posedge aclk);
            acc = in_ready;
            if (!in_ready)
                saw_low = 1'b1;
            @(negedge aclk);
            if (acc)
                next_pc = next_pc + 4;
        end
        in_valid = 1'b0;
        assert (saw_low) else
        begin
            failures++;
            $display("in_ready never dropped while retire_ready was low");
        end
        rr_mode = 0;
        while (ref_q.size() != 0)
            @(negedge aclk);
        repeat (4) @(negedge aclk);

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
